// ==== channel_arb.sv ====
`include "mem_subsys_macros.svh"

module channel_arb
    import mem_subsys_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    redirect,             // Core redirect pulse

    // PC fetch channel, burst read
    input  logic                    pc_index_valid,
    input  logic [`MEM_INDEX_W-1:0] pc_index,
    output logic                    pc_index_ready,
    output logic [`MEM_LINE_W-1:0]  pc_read_inst,         // Zero outside PC done
    output logic                    pc_operation_done,

    // Store channel, masked word write
    input  logic                    store_index_valid,
    input  logic [`MEM_INDEX_W-1:0] store_index,
    input  mem_word_t               store_write_mask,     // One bit selects new data
    input  mem_word_t               store_write_data,
    output logic                    store_index_ready,
    output logic                    store_operation_done,

    // Load channel, single word read
    input  logic                    load_index_valid,
    input  logic [`MEM_INDEX_W-1:0] load_index,
    output logic                    load_index_ready,
    output mem_word_t               load_read_data,       // Zero outside load done
    output logic                    load_operation_done,

    // Memory command
    output logic                    ddr_chip_enable,      // One cycle per accepted command
    output logic [`MEM_INDEX_W-1:0] ddr_index,
    output logic                    ddr_write_enable,
    output logic                    ddr_burst_mode,       // Set for PC fetch only
    output mem_word_t               ddr_write_mask,
    output mem_word_t               ddr_write_data,

    // Memory answer
    input  mem_word_t               ddr_read_data,
    input  logic [`MEM_LINE_W-1:0]  ddr_read_line,
    input  logic                    ddr_operation_done,
    input  logic                    ddr_ready,            // Idle or finishing this cycle

    output logic [`MEM_INDEX_W-1:0] pc_line_index         // Index of last PC command
);

    logic redirect_q1;                                    // Redirect one cycle back
    logic redirect_q2;                                    // Redirect two cycles back
    logic redirect_fire;                                  // Forced refetch this cycle

    logic store_grant;
    logic load_grant;
    logic pc_grant;

    logic owner_store;                                    // Channel of the command in flight
    logic owner_load;
    logic owner_pc;

    // Two stage delay on redirect, falling edge shows as 1 then 0
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            redirect_q1 <= 1'b0;
            redirect_q2 <= 1'b0;
        end else begin
            redirect_q1 <= redirect;
            redirect_q2 <= redirect_q1;
        end
    end

    // Only while the memory is busy, an idle memory takes the normal path
    assign redirect_fire = !ddr_ready && !redirect_q1 && redirect_q2;

    // Fixed priority, store over load over PC
    always_comb begin
        store_grant = 1'b0;
        load_grant  = 1'b0;
        pc_grant    = 1'b0;
        if (ddr_ready) begin
            if (store_index_valid) begin
                store_grant = 1'b1;
            end else if (load_index_valid) begin
                load_grant = 1'b1;
            end else if (pc_index_valid) begin
                pc_grant = 1'b1;
            end
        end else if (redirect_fire) begin
            pc_grant = 1'b1;                              // Restart the fetch mid burst
        end
    end

    assign store_index_ready = store_grant;
    assign load_index_ready  = load_grant;
    assign pc_index_ready    = pc_grant;

    // Steer the granted request onto the command lines
    always_comb begin
        ddr_chip_enable  = store_grant | load_grant | pc_grant;
        ddr_write_enable = store_grant;
        ddr_burst_mode   = pc_grant;
        ddr_index        = '0;
        ddr_write_mask   = '0;                            // Mask and data only for stores
        ddr_write_data   = '0;
        if (store_grant) begin
            ddr_index      = store_index;
            ddr_write_mask = store_write_mask;
            ddr_write_data = store_write_data;
        end else if (load_grant) begin
            ddr_index = load_index;
        end else if (pc_grant) begin
            ddr_index = pc_index;
        end
    end

    // Owner follows every issued command, redirect keeps PC as owner
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            owner_store <= 1'b0;
            owner_load  <= 1'b0;
            owner_pc    <= 1'b0;
        end else if (ddr_chip_enable) begin
            owner_store <= store_grant;
            owner_load  <= load_grant;
            owner_pc    <= pc_grant;
        end
    end

    // Line tag for the fetch buffer
    always_ff @(posedge clock) begin
        if (pc_grant) begin
            pc_line_index <= pc_index;
        end
    end

    // Done goes back only to the owner
    assign store_operation_done = owner_store && ddr_operation_done;
    assign load_operation_done  = owner_load && ddr_operation_done;
    assign pc_operation_done    = owner_pc && ddr_operation_done;

    // Read data passes only in the owner's done cycle
    assign load_read_data = (ddr_ready && load_operation_done) ? ddr_read_data : '0;
    assign pc_read_inst   = (ddr_ready && pc_operation_done) ? ddr_read_line : '0;

endmodule

// ==== ddr_model.sv ====
`include "mem_subsys_macros.svh"

module ddr_model
    import mem_subsys_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset_n,

    // Command from the arbiter
    input  logic                    ddr_chip_enable,      // New command, aborts a busy one
    input  logic [`MEM_INDEX_W-1:0] ddr_index,
    input  logic                    ddr_write_enable,
    input  logic                    ddr_burst_mode,
    input  mem_word_t               ddr_write_mask,
    input  mem_word_t               ddr_write_data,

    // Answer to the arbiter
    output logic                    ddr_ready,
    output logic                    ddr_operation_done,
    output mem_word_t               ddr_read_data,
    output logic [`MEM_LINE_W-1:0]  ddr_read_line
);

    localparam int DEPTH        = 1 << `MEM_DEPTH_LOG2;
    localparam int BEAT_W       = $clog2(`MEM_LINE_WORDS);
    localparam int WORD_CYCLES  = `DDR_LATENCY - 1;                       // Busy cycles, word
    localparam int BURST_CYCLES = `DDR_LATENCY - 1 + `MEM_LINE_WORDS - 1; // Busy cycles, burst
    localparam int CNT_W        = $clog2(BURST_CYCLES + 1);

    // Word store, powers up cleared
    mem_word_t mem [DEPTH] = '{default: '0};

    logic                              busy;              // Command in flight
    logic                              burst_q;           // In-flight command is a burst
    logic [CNT_W-1:0]                  count;             // Cycles left until done
    logic [`MEM_DEPTH_LOG2-1:0]        word_addr;         // Aliased word address
    logic [`MEM_DEPTH_LOG2-BEAT_W-1:0] line_base;         // Line address of the burst
    logic                              beat_active;       // A burst beat lands this cycle
    logic [BEAT_W-1:0]                 beat;              // Word number of that beat
    mem_word_t                         read_q;            // Word read result
    fetch_line_u                       line_q;            // Burst line under assembly

    assign word_addr = ddr_index[`MEM_DEPTH_LOG2-1:0];    // Upper index bits ignored

    // Done in the last busy cycle, ready again in the same cycle
    assign ddr_operation_done = busy && (count == '0);
    assign ddr_ready          = !busy || ddr_operation_done;

    // Beats run in the last eight cycles before done, word 0 first
    assign beat_active = busy && burst_q && (count != '0) &&
                         (count <= CNT_W'(`MEM_LINE_WORDS));
    assign beat        = BEAT_W'(`MEM_LINE_WORDS - int'(count));

    // Latency counter
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy    <= 1'b0;
            burst_q <= 1'b0;
            count   <= '0;
        end else if (ddr_chip_enable) begin
            busy    <= 1'b1;                              // Old operation dropped, no done
            burst_q <= ddr_burst_mode;
            if (ddr_burst_mode) begin
                count <= CNT_W'(BURST_CYCLES);
            end else begin
                count <= CNT_W'(WORD_CYCLES);
            end
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;                             // Done cycle over
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Array access and line assembly
    always_ff @(posedge clock) begin
        if (ddr_chip_enable) begin
            line_base <= ddr_index[`MEM_DEPTH_LOG2-1:BEAT_W]; // Low three bits cleared
            if (ddr_write_enable) begin
                // Mask bit 1 takes new data, 0 keeps the stored bit
                mem[word_addr] <= (mem[word_addr] & ~ddr_write_mask) |
                                  (ddr_write_data & ddr_write_mask);
            end else if (!ddr_burst_mode) begin
                read_q <= mem[word_addr];                 // Held until done
            end
        end
        if (beat_active) begin
            line_q.words[beat] <= mem[{line_base, beat}]; // Word k from base + k
        end
    end

    assign ddr_read_data = read_q;
    assign ddr_read_line = line_q;

endmodule

// ==== fetch_line_buffer.sv ====
`include "mem_subsys_macros.svh"

module fetch_line_buffer
    import mem_subsys_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset_n,

    // Completed fetch from the arbiter
    input  logic                    pc_operation_done,    // Line present this cycle
    input  logic [`MEM_LINE_W-1:0]  pc_read_inst,
    input  logic [`MEM_INDEX_W-1:0] pc_line_index,        // Index the line was fetched with

    // Instruction select from the core
    input  logic [`MEM_SLOT_W-1:0]  fetch_slot,

    output logic                    fetch_line_valid,     // Held line is usable
    output logic [`MEM_INDEX_W-1:0] fetch_line_tag,
    output logic [`MEM_INST_W-1:0]  fetch_inst
);

    fetch_line_u line_q;                                  // Last completed line

    // Stays set once the first line has arrived
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fetch_line_valid <= 1'b0;
        end else if (pc_operation_done) begin
            fetch_line_valid <= 1'b1;
        end
    end

    // Capture on the edge that ends the done cycle
    always_ff @(posedge clock) begin
        if (pc_operation_done) begin
            line_q         <= fetch_line_u'(pc_read_inst);
            fetch_line_tag <= pc_line_index;              // Full index kept as tag
        end
    end

    // Slot pick is combinational, even slots are low word halves
    assign fetch_inst = line_q.insts[fetch_slot];

endmodule

// ==== mem_subsys.f ====
+incdir+.
mem_subsys_pkg.sv
channel_arb.sv
ddr_model.sv
fetch_line_buffer.sv
mem_subsys.sv
mem_subsys_asserts.sv
tb_mem_subsys.sv

// ==== mem_subsys.sv ====
`include "mem_subsys_macros.svh"

module mem_subsys
    import mem_subsys_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    redirect,             // Aborts and reissues a PC burst

    // PC fetch channel
    input  logic                    pc_index_valid,
    input  logic [`MEM_INDEX_W-1:0] pc_index,
    output logic                    pc_index_ready,
    output logic [`MEM_LINE_W-1:0]  pc_read_inst,
    output logic                    pc_operation_done,

    // Store channel
    input  logic                    store_index_valid,
    input  logic [`MEM_INDEX_W-1:0] store_index,
    input  mem_word_t               store_write_mask,
    input  mem_word_t               store_write_data,
    output logic                    store_index_ready,
    output logic                    store_operation_done,

    // Load channel
    input  logic                    load_index_valid,
    input  logic [`MEM_INDEX_W-1:0] load_index,
    output logic                    load_index_ready,
    output mem_word_t               load_read_data,
    output logic                    load_operation_done,

    // Fetch line buffer
    input  logic [`MEM_SLOT_W-1:0]  fetch_slot,
    output logic                    fetch_line_valid,
    output logic [`MEM_INDEX_W-1:0] fetch_line_tag,
    output logic [`MEM_INST_W-1:0]  fetch_inst
);

    // Command path, arbiter to memory
    logic                    ddr_chip_enable;
    logic [`MEM_INDEX_W-1:0] ddr_index;
    logic                    ddr_write_enable;
    logic                    ddr_burst_mode;
    mem_word_t               ddr_write_mask;
    mem_word_t               ddr_write_data;

    // Answer path, memory to arbiter
    logic                    ddr_ready;
    logic                    ddr_operation_done;
    mem_word_t               ddr_read_data;
    logic [`MEM_LINE_W-1:0]  ddr_read_line;

    logic [`MEM_INDEX_W-1:0] pc_line_index;               // Tag for the fetch buffer

    channel_arb channel_arb_inst (
        .clock                (clock),
        .reset_n              (reset_n),
        .redirect             (redirect),
        .pc_index_valid       (pc_index_valid),
        .pc_index             (pc_index),
        .pc_index_ready       (pc_index_ready),
        .pc_read_inst         (pc_read_inst),
        .pc_operation_done    (pc_operation_done),
        .store_index_valid    (store_index_valid),
        .store_index          (store_index),
        .store_write_mask     (store_write_mask),
        .store_write_data     (store_write_data),
        .store_index_ready    (store_index_ready),
        .store_operation_done (store_operation_done),
        .load_index_valid     (load_index_valid),
        .load_index           (load_index),
        .load_index_ready     (load_index_ready),
        .load_read_data       (load_read_data),
        .load_operation_done  (load_operation_done),
        .ddr_chip_enable      (ddr_chip_enable),
        .ddr_index            (ddr_index),
        .ddr_write_enable     (ddr_write_enable),
        .ddr_burst_mode       (ddr_burst_mode),
        .ddr_write_mask       (ddr_write_mask),
        .ddr_write_data       (ddr_write_data),
        .ddr_read_data        (ddr_read_data),
        .ddr_read_line        (ddr_read_line),
        .ddr_operation_done   (ddr_operation_done),
        .ddr_ready            (ddr_ready),
        .pc_line_index        (pc_line_index)
    );

    ddr_model ddr_model_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .ddr_chip_enable    (ddr_chip_enable),
        .ddr_index          (ddr_index),
        .ddr_write_enable   (ddr_write_enable),
        .ddr_burst_mode     (ddr_burst_mode),
        .ddr_write_mask     (ddr_write_mask),
        .ddr_write_data     (ddr_write_data),
        .ddr_ready          (ddr_ready),
        .ddr_operation_done (ddr_operation_done),
        .ddr_read_data      (ddr_read_data),
        .ddr_read_line      (ddr_read_line)
    );

    fetch_line_buffer fetch_line_buffer_inst (
        .clock             (clock),
        .reset_n           (reset_n),
        .pc_operation_done (pc_operation_done),
        .pc_read_inst      (pc_read_inst),
        .pc_line_index     (pc_line_index),
        .fetch_slot        (fetch_slot),
        .fetch_line_valid  (fetch_line_valid),
        .fetch_line_tag    (fetch_line_tag),
        .fetch_inst        (fetch_inst)
    );

endmodule

// ==== mem_subsys_asserts.sv ====
`include "mem_subsys_macros.svh"

module mem_subsys_asserts
    import mem_subsys_pkg::*;
(
    input logic clock,
    input logic reset_n,
    input logic redirect,                                         // Core redirect pulse
    input logic store_index_valid,
    input logic load_index_valid,
    input logic pc_index_valid,
    input logic store_index_ready,
    input logic load_index_ready,
    input logic pc_index_ready,
    input logic store_operation_done,
    input logic load_operation_done,
    input logic pc_operation_done,
    input logic ddr_chip_enable,
    input logic ddr_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;                                           // Read by the testbench

    // Quiet handshake while in reset
    a_reset_idle: assert property (@(posedge clock) !reset_n |->
        !(store_index_ready | load_index_ready | pc_index_ready | ddr_chip_enable |
          store_operation_done | load_operation_done | pc_operation_done))
        else begin
            $error("handshake active in reset");
            fail_count++;
        end

    a_ready_onehot: assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0({store_index_ready, load_index_ready, pc_index_ready}))
        else begin
            $error("more than one ready");
            fail_count++;
        end

    // Idle memory grants the highest valid channel
    a_priority: assert property (@(posedge clock) disable iff (!reset_n) ddr_ready |->
        (store_index_ready == store_index_valid) &&
        (load_index_ready == (load_index_valid && !store_index_valid)) &&
        (pc_index_ready == (pc_index_valid && !store_index_valid && !load_index_valid)))
        else begin
            $error("ready not on highest valid channel");
            fail_count++;
        end

    // Busy memory only takes the forced PC refetch, two cycles after redirect falls
    a_busy_ready: assert property (@(posedge clock) disable iff (!reset_n) !ddr_ready |->
        (pc_index_ready == ($past(redirect, 2) && !$past(redirect, 1))) &&
        !store_index_ready && !load_index_ready)
        else begin
            $error("ready while memory busy");
            fail_count++;
        end

    a_busy_enable: assert property (@(posedge clock) disable iff (!reset_n)
        ddr_chip_enable && !ddr_ready |-> $past(redirect, 2) && !$past(redirect, 1))
        else begin
            $error("command issued while memory busy");
            fail_count++;
        end

    a_done_onehot: assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0({store_operation_done, load_operation_done, pc_operation_done}))
        else begin
            $error("done on more than one channel");
            fail_count++;
        end

endmodule

bind channel_arb mem_subsys_asserts mem_subsys_asserts_inst (.*);

// ==== mem_subsys_macros.svh ====
`ifndef MEM_SUBSYS_MACROS_SVH
`define MEM_SUBSYS_MACROS_SVH

// Memory word index, one index per 64-bit word
`define MEM_INDEX_W 19

`define MEM_WORD_W 64                                   // Load and store data word
`define MEM_LINE_W 512                                  // One burst line per fetch
`define MEM_INST_W 32                                   // Single instruction

// Line geometry, follows from the widths above
`define MEM_LINE_WORDS (`MEM_LINE_W / `MEM_WORD_W)      // Beats per burst
`define MEM_LINE_INSTS (`MEM_LINE_W / `MEM_INST_W)      // Instruction slots per line
`define MEM_SLOT_W     $clog2(`MEM_LINE_INSTS)          // Slot select width

// Memory model
`define MEM_DEPTH_LOG2 10                               // Stored words, upper index bits alias
`define DDR_LATENCY    4                                // Command to done for one word

`endif

// ==== mem_subsys_pkg.sv ====
`include "mem_subsys_macros.svh"

package mem_subsys_pkg;

    // Data word as carried by the load and store channels
    typedef logic [`MEM_WORD_W-1:0] mem_word_t;

    // One fetch line
    // The memory model fills it beat by beat as words,
    // the fetch buffer reads it back as instruction slots.
    // Slot 2k is the low half of word k, slot 2k+1 the high half
    typedef union packed {
        mem_word_t [`MEM_LINE_WORDS-1:0]             words;  // Word k from line base + k
        logic [`MEM_LINE_INSTS-1:0][`MEM_INST_W-1:0] insts;  // 32-bit instruction slots
    } fetch_line_u;

endpackage

// ==== tb_mem_subsys.sv ====
`include "mem_subsys_macros.svh"

module tb_mem_subsys
    import mem_subsys_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IW       = `MEM_INDEX_W;
    localparam int N_PAIRS  = 12;                                 // Store and load pairs
    localparam int REQUESTS = 2 * N_PAIRS + 3 + 9 + 3 + 2;        // Summed over tests 2 to 6
    localparam int TIMEOUT  = 2 * REQUESTS * (`DDR_LATENCY + 8) + 100;
    localparam int CH_PC    = 0;
    localparam int CH_LOAD  = 1;
    localparam int CH_STORE = 2;

    logic                   clock = 1'b0;
    logic                   reset_n;
    logic                   redirect;
    logic                   pc_index_valid, load_index_valid, store_index_valid;
    logic [IW-1:0]          pc_index, load_index, store_index;
    logic                   pc_index_ready, load_index_ready, store_index_ready;
    logic                   pc_operation_done, load_operation_done, store_operation_done;
    logic [`MEM_LINE_W-1:0] pc_read_inst;
    mem_word_t              store_write_mask, store_write_data, load_read_data;
    logic [3:0]             fetch_slot;
    logic                   fetch_line_valid;
    logic [IW-1:0]          fetch_line_tag;
    logic [`MEM_INST_W-1:0] fetch_inst;

    mem_word_t ref_mem [1 << `MEM_DEPTH_LOG2];                    // Expected memory contents
    integer    seed = 53;
    int        errors = 0;
    int        mark = 0;                                          // Error count at test start
    int        tests = 0;
    int        failed = 0;
    int        cycle_count = 0;

    mem_subsys mem_subsys_inst (.*);

    always #4 clock = ~clock;                                     // 8 ns period

    initial begin
        while (cycle_count < TIMEOUT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, a request or done never came", cycle_count);
        $display("Result: FAILED");
        $finish;
    end

    function automatic int all_errors();
        return errors + mem_subsys_inst.channel_arb_inst.mem_subsys_asserts_inst.fail_count;
    endfunction

    task automatic check_value(input string name, input logic [`MEM_LINE_W-1:0] expected,
                               input logic [`MEM_LINE_W-1:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s expected %0h got %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond === 1'b1) else begin
            $display("Check failed, %s", what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (all_errors() != mark) failed++;
        $display("Test %0d %s %s", tests, name, (all_errors() == mark) ? "ok" : "failed");
        mark = all_errors();
    endtask

    function automatic mem_word_t ref_word(input logic [IW-1:0] idx);
        return ref_mem[idx[`MEM_DEPTH_LOG2-1:0]];                 // Upper bits alias
    endfunction

    // Word k of the line is the word at the aligned base plus k
    function automatic logic [`MEM_LINE_W-1:0] ref_line(input logic [IW-1:0] idx);
        logic [`MEM_LINE_W-1:0] line;
        for (int k = 0; k < 8; k++) begin
            line[64*k +: 64] = ref_word({idx[IW-1:3], 3'(k)});
        end
        return line;
    endfunction

    // Returns on the falling edge right after acceptance
    task automatic wait_ready(input int ch);
        #1;
        while (!(ch == CH_STORE ? store_index_ready :
                 ch == CH_LOAD  ? load_index_ready : pc_index_ready)) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
    endtask

    task automatic finish_store();
        wait_ready(CH_STORE);
        store_index_valid = 1'b0;
        ref_mem[store_index[`MEM_DEPTH_LOG2-1:0]] =
            (ref_mem[store_index[`MEM_DEPTH_LOG2-1:0]] & ~store_write_mask) |
            (store_write_data & store_write_mask);                // Mask one takes new bit
        while (!store_operation_done) @(negedge clock);
    endtask

    task automatic store_word(input logic [IW-1:0] idx, input mem_word_t mask,
                              input mem_word_t data);
        @(negedge clock);
        store_index       = idx;
        store_write_mask  = mask;
        store_write_data  = data;
        store_index_valid = 1'b1;
        finish_store();
    endtask

    task automatic load_word(input logic [IW-1:0] idx, output mem_word_t data);
        @(negedge clock);
        load_index       = idx;
        load_index_valid = 1'b1;
        wait_ready(CH_LOAD);
        load_index_valid = 1'b0;
        while (!load_operation_done) @(negedge clock);
        data = load_read_data;                                    // Valid in the done cycle
    endtask

    task automatic fetch_line(input logic [IW-1:0] idx, output logic [`MEM_LINE_W-1:0] line);
        @(negedge clock);
        pc_index       = idx;
        pc_index_valid = 1'b1;
        wait_ready(CH_PC);
        pc_index_valid = 1'b0;
        while (!pc_operation_done) @(negedge clock);
        line = pc_read_inst;
    endtask

    initial begin
        mem_word_t              got;
        logic [IW-1:0]          idx;
        logic [IW-1:0]          base;
        logic [`MEM_LINE_W-1:0] line;
        int                     served;
        reset_n           = 1'b0;
        redirect          = 1'b0;
        pc_index_valid    = 1'b0;
        load_index_valid  = 1'b0;
        store_index_valid = 1'b0;
        pc_index          = '0;
        load_index        = '0;
        store_index       = '0;
        store_write_mask  = '0;
        store_write_data  = '0;
        fetch_slot        = '0;
        idx               = '0;
        base              = IW'('h208);                           // Line aligned
        for (int i = 0; i < (1 << `MEM_DEPTH_LOG2); i++) begin
            ref_mem[i] = '0;                                      // Model powers up cleared
        end

        // Test 1, idle outputs in and right after reset
        repeat (8) @(posedge clock);
        @(negedge clock);
        check_true("handshake active in reset", !(pc_index_ready | load_index_ready |
                   store_index_ready | pc_operation_done | load_operation_done |
                   store_operation_done | mem_subsys_inst.ddr_chip_enable));
        reset_n = 1'b1;
        @(negedge clock);
        check_true("line valid or chip enable set after reset",
                   !fetch_line_valid && !mem_subsys_inst.ddr_chip_enable);
        end_test("reset");

        // Test 2, masked stores read back through an aliased index
        for (int i = 0; i < N_PAIRS; i++) begin
            if (i != N_PAIRS - 1) begin
                idx = IW'($random(seed));                         // Last pass reuses index
            end
            store_word(idx, (i == N_PAIRS - 1) ? '0 : {$random(seed), $random(seed)},
                       {$random(seed), $random(seed)});
            load_word(idx ^ IW'(1 << `MEM_DEPTH_LOG2), got);
            check_value("load_read_data", ref_word(idx), got);
        end
        end_test("store_load");

        // Test 3, all three channels valid together
        @(negedge clock);
        store_index       = base;
        store_write_mask  = '1;
        store_write_data  = {$random(seed), $random(seed)};
        load_index        = base;
        pc_index          = base;
        store_index_valid = 1'b1;
        load_index_valid  = 1'b1;
        pc_index_valid    = 1'b1;
        served            = 0;
        while (served < 100) begin                                // Three digits, one per grant
            #1;
            if (store_index_ready) begin
                served = served * 10 + CH_STORE + 1;
                ref_mem[base[`MEM_DEPTH_LOG2-1:0]] = store_write_data;
                @(negedge clock);
                store_index_valid = 1'b0;
            end else if (load_index_ready) begin
                served = served * 10 + CH_LOAD + 1;
                @(negedge clock);
                load_index_valid = 1'b0;
            end else if (pc_index_ready) begin
                served = served * 10 + CH_PC + 1;
                @(negedge clock);
                pc_index_valid = 1'b0;
            end else begin
                @(negedge clock);
            end
        end
        check_true("channels not served store, load, PC", served == 321);
        while (!pc_operation_done) @(negedge clock);
        end_test("priority");

        // Test 4, burst line and all instruction slots
        for (int k = 0; k < 8; k++) begin
            store_word(base + IW'(k), '1, {$random(seed), $random(seed)});
        end
        fetch_line(base + 5, line);
        check_value("pc_read_inst", ref_line(base + 5), line);
        line = ref_line(base + 5);                                // Expected slot contents
        @(negedge clock);
        check_true("fetch_line_valid low after a fetch", fetch_line_valid);
        check_value("fetch_line_tag", base + 5, fetch_line_tag);
        for (int s = 0; s < 16; s++) begin
            @(negedge clock);
            fetch_slot = 4'(s);
            #1;
            check_value("fetch_inst", line[32*s +: 32], fetch_inst);  // Even slot low half
        end
        end_test("burst_fetch");

        // Test 5, store waits behind a load
        @(negedge clock);
        load_index       = base;
        load_index_valid = 1'b1;
        wait_ready(CH_LOAD);
        load_index_valid  = 1'b0;
        store_index       = base + 1;
        store_write_mask  = {$random(seed), $random(seed)};
        store_write_data  = {$random(seed), $random(seed)};
        store_index_valid = 1'b1;
        while (!load_operation_done) begin
            #1;
            check_true("store accepted while memory busy", !store_index_ready);
            @(negedge clock);
        end
        check_value("load_read_data", ref_word(base), load_read_data);
        finish_store();
        load_word(base + 1, got);
        check_value("load_read_data", ref_word(base + 1), got);
        end_test("back_pressure");

        // Test 6, redirect mid burst refetches the new index
        @(negedge clock);
        pc_index       = IW'('h300);
        pc_index_valid = 1'b1;
        wait_ready(CH_PC);
        pc_index_valid = 1'b0;
        pc_index       = base + 2;                                // Target of the refetch
        @(negedge clock);
        redirect = 1'b1;
        @(negedge clock);
        redirect = 1'b0;
        while (!pc_operation_done) @(negedge clock);
        check_value("pc_read_inst", ref_line(base + 2), pc_read_inst);
        @(negedge clock);
        check_value("fetch_line_tag", base + 2, fetch_line_tag);
        repeat (`DDR_LATENCY + 8) begin
            check_true("second PC done after redirect", !pc_operation_done);
            @(negedge clock);
        end
        end_test("redirect");

        $display("Tests %0d, failed %0d, errors %0d", tests, failed, all_errors());
        if (all_errors() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
